// ==== common/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// datapath and bus sizes
`define ALU_DATA_W 32
`define ALU_ADR_W 3

// enough for a count of 16 steps
`define ALU_SHIFT_CNT_W 5

`endif

// ==== common/alu_op_pkg.sv ====
`default_nettype none

package alu_op_pkg;

    // arithmetic and logic first, then the eight shifts
    typedef enum logic [3:0] {
        alu_add, alu_adc, alu_sub, alu_sbc,
        alu_cp,  alu_and, alu_or,  alu_xor,
        alu_rlc, alu_rrc, alu_rl,  alu_rr,
        alu_sla, alu_sra, alu_sll, alu_srl
    } alu_op_e;

    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_word = 2'd1,
        width_long = 2'd2
    } alu_width_e;

    typedef logic [7:0] alu_flags_t;

    localparam int flag_s_bit = 7;
    localparam int flag_z_bit = 6;
    localparam int flag_h_bit = 4;
    localparam int flag_v_bit = 2;  // overflow or parity
    localparam int flag_n_bit = 1;
    localparam int flag_c_bit = 0;

endpackage

`default_nettype wire

// ==== common/alu_bus_pkg.sv ====
`default_nettype none

package alu_bus_pkg;

    typedef enum logic [2:0] {
        reg_opa    = 3'd0,
        reg_opb    = 3'd1,
        reg_flags  = 3'd2,
        reg_cmd    = 3'd3,  // write launches the operation
        reg_result = 3'd4
    } reg_addr_e;

    localparam int cmd_op_lsb    = 0;  // opcode in bits 3..0
    localparam int cmd_width_lsb = 4;  // width in bits 5..4

endpackage

`default_nettype wire

// ==== alu_core/alu_shift.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "alu_cfg.svh"

module alu_shift (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  alu_op_pkg::alu_op_e    op,
    input  alu_op_pkg::alu_width_e width,
    input  logic [`ALU_DATA_W-1:0] value,
    input  logic [3:0]             count,
    input  logic                   carry_in,
    output logic                   busy,
    output logic                   last,
    output logic [`ALU_DATA_W-1:0] shifted,
    output logic                   carry_out
);
    import alu_op_pkg::*;

    logic [`ALU_DATA_W-1:0]      val_q;
    logic                        c_q;
    logic [`ALU_SHIFT_CNT_W-1:0] cnt_q;
    logic [`ALU_SHIFT_CNT_W-1:0] steps;  // steps left, this one included
    logic [`ALU_DATA_W-1:0]      cur;
    logic                        cur_c;
    logic                        left;
    logic                        msb;
    logic                        fill;

    // first step runs in the start cycle straight from the inputs
    assign cur   = start ? value : val_q;
    assign cur_c = start ? carry_in : c_q;
    assign steps = !start ? cnt_q :
                   (count == 4'd0) ? `ALU_SHIFT_CNT_W'(16) : `ALU_SHIFT_CNT_W'(count);
    assign last  = (start | busy) & (steps == `ALU_SHIFT_CNT_W'(1));
    assign left  = op inside {alu_rlc, alu_rl, alu_sla, alu_sll};

    always_comb begin
        case (width)
            width_byte: msb = cur[7];
            width_word: msb = cur[15];
            default:    msb = cur[31];
        endcase
        case (op)
            alu_rlc:        fill = msb;
            alu_rrc:        fill = cur[0];
            alu_rl, alu_rr: fill = cur_c;  // through carry
            alu_sra:        fill = msb;    // sign kept
            default:        fill = 1'b0;
        endcase
    end

    always_comb begin
        shifted = cur;
        case (width)
            width_byte: shifted[7:0] = left ? {cur[6:0], fill} : {fill, cur[7:1]};
            width_word: shifted[15:0] = left ? {cur[14:0], fill} : {fill, cur[15:1]};
            default:    shifted = left ? {cur[30:0], fill} : {fill, cur[31:1]};
        endcase
    end

    assign carry_out = left ? msb : cur[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            cnt_q <= '0;
        end else if (start || busy) begin
            busy  <= ~last;
            cnt_q <= steps - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            val_q <= shifted;
            c_q   <= carry_out;
        end
    end

    // one shift in flight at a time
    assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

// ==== alu_core/alu_execute.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "alu_cfg.svh"

module alu_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  alu_op_pkg::alu_op_e    op,
    input  alu_op_pkg::alu_width_e width,
    input  logic [`ALU_DATA_W-1:0] opa,
    input  logic [`ALU_DATA_W-1:0] opb,
    input  alu_op_pkg::alu_flags_t flags,
    output logic                   valid,
    output logic                   write_result,
    output logic [`ALU_DATA_W-1:0] next_result,
    output alu_op_pkg::alu_flags_t next_flags
);
    import alu_op_pkg::*;

    logic                   is_shift;
    logic                   is_logic;
    logic                   is_sub;
    logic                   cin;
    logic [`ALU_DATA_W-1:0] mask;
    logic [`ALU_DATA_W-1:0] arith;
    logic                   half_c;
    logic [2:0]             cc;  // carry out of bits 7, 15 and 31
    logic [`ALU_DATA_W-1:0] raw;
    logic                   res_h;
    logic                   res_c;
    logic                   ovf;
    logic                   parity_even;
    logic                   sh_start;
    logic                   sh_busy;
    logic                   sh_last;
    logic [`ALU_DATA_W-1:0] sh_value;
    logic                   sh_carry;

    function automatic logic top_bit(input logic [`ALU_DATA_W-1:0] v, input alu_width_e w);
        case (w)
            width_byte: return v[7];
            width_word: return v[15];
            default:    return v[31];
        endcase
    endfunction

    assign is_shift = op inside {alu_rlc, alu_rrc, alu_rl, alu_rr,
                                 alu_sla, alu_sra, alu_sll, alu_srl};
    assign is_logic = op inside {alu_and, alu_or, alu_xor};
    assign is_sub   = op inside {alu_sub, alu_sbc, alu_cp};
    assign cin      = (op == alu_adc || op == alu_sbc) ? flags[flag_c_bit] : 1'b0;
    assign sh_start = start & is_shift;

    always_comb begin
        case (width)
            width_byte: mask = 32'h0000_00ff;
            width_word: mask = 32'h0000_ffff;
            default:    mask = '1;
        endcase
    end

    // chained nibble, byte, word and long stages give H and the per-width carries
    always_comb begin
        if (is_sub) begin
            {half_c, arith[3:0]} = {1'b0, opa[3:0]} - {1'b0, opb[3:0]} - {4'd0, cin};
            {cc[0], arith[7:4]}  = {1'b0, opa[7:4]} - {1'b0, opb[7:4]} - {4'd0, half_c};
            {cc[1], arith[15:8]} = {1'b0, opa[15:8]} - {1'b0, opb[15:8]} - {8'd0, cc[0]};
            {cc[2], arith[31:16]} = {1'b0, opa[31:16]} - {1'b0, opb[31:16]} - {16'd0, cc[1]};
        end else begin
            {half_c, arith[3:0]} = {1'b0, opa[3:0]} + {1'b0, opb[3:0]} + {4'd0, cin};
            {cc[0], arith[7:4]}  = {1'b0, opa[7:4]} + {1'b0, opb[7:4]} + {4'd0, half_c};
            {cc[1], arith[15:8]} = {1'b0, opa[15:8]} + {1'b0, opb[15:8]} + {8'd0, cc[0]};
            {cc[2], arith[31:16]} = {1'b0, opa[31:16]} + {1'b0, opb[31:16]} + {16'd0, cc[1]};
        end
    end

    always_comb begin
        raw   = arith;
        res_h = half_c;
        case (width)
            width_byte: res_c = cc[0];
            width_word: res_c = cc[1];
            default:    res_c = cc[2];
        endcase
        if (is_shift) begin
            raw   = sh_value;
            res_h = 1'b0;
            res_c = sh_carry;  // last bit out
        end else if (is_logic) begin
            res_h = (op == alu_and);
            res_c = 1'b0;
            case (op)
                alu_and: raw = opa & opb;
                alu_or:  raw = opa | opb;
                default: raw = opa ^ opb;
            endcase
        end
    end

    // bits above the width keep opa
    assign next_result = (opa & ~mask) | (raw & mask);

    assign parity_even = (width == width_byte) ? ~^next_result[7:0] : ~^next_result[15:0];
    assign ovf = is_sub
        ? (top_bit(opa, width) ^ top_bit(opb, width)) & (top_bit(next_result, width) ^ top_bit(opa, width))
        : ~(top_bit(opa, width) ^ top_bit(opb, width)) & (top_bit(next_result, width) ^ top_bit(opa, width));

    always_comb begin
        next_flags             = '0;
        next_flags[flag_s_bit] = top_bit(next_result, width);
        next_flags[flag_z_bit] = (next_result & mask) == '0;
        next_flags[flag_h_bit] = res_h;
        next_flags[flag_v_bit] = (is_shift || is_logic) ? parity_even : ovf;
        next_flags[flag_n_bit] = is_sub;
        next_flags[flag_c_bit] = res_c;
    end

    assign valid        = (start & ~is_shift) | sh_last;
    assign write_result = (op != alu_cp);  // compare only touches flags

    alu_shift u_shift (
        .clk       (clk),
        .rst       (rst),
        .start     (sh_start),
        .op        (op),
        .width     (width),
        .value     (opa),
        .count     (opb[3:0]),
        .carry_in  (flags[flag_c_bit]),
        .busy      (sh_busy),
        .last      (sh_last),
        .shifted   (sh_value),
        .carry_out (sh_carry)
    );

    // no command of any kind is launched into a running shift
    assert property (@(posedge clk) disable iff (rst) sh_busy |-> !start);

endmodule

`default_nettype wire

// ==== source/alu_result.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "alu_cfg.svh"

module alu_result (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  logic                   write_result,
    input  logic [`ALU_DATA_W-1:0] next_result,
    input  alu_op_pkg::alu_flags_t next_flags,
    input  logic                   flag_wr,
    input  alu_op_pkg::alu_flags_t flag_wdata,
    output logic [`ALU_DATA_W-1:0] result,
    output alu_op_pkg::alu_flags_t flags,
    output logic                   done
);
    import alu_op_pkg::*;

    // unused flag bits always read as zero
    localparam alu_flags_t flag_mask = alu_flags_t'((1 << flag_s_bit) | (1 << flag_z_bit) |
                                                    (1 << flag_h_bit) | (1 << flag_v_bit) |
                                                    (1 << flag_n_bit) | (1 << flag_c_bit));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
            flags  <= '0;
            done   <= 1'b0;
        end else begin
            done <= valid;
            if (valid) begin
                if (write_result)
                    result <= next_result;
                flags <= next_flags;
            end else if (flag_wr) begin
                flags <= flag_wdata & flag_mask;  // preset, e.g. C for adc
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/alu_decode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "alu_cfg.svh"

module alu_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`ALU_ADR_W-1:0]  adr,
    input  logic [`ALU_DATA_W-1:0] dat_w,
    output logic                   ack,
    output logic [`ALU_DATA_W-1:0] dat_r,
    output logic                   start,
    output alu_op_pkg::alu_op_e    op,
    output alu_op_pkg::alu_width_e width,
    output logic [`ALU_DATA_W-1:0] opa,
    output logic [`ALU_DATA_W-1:0] opb,
    output logic                   flag_wr,
    output alu_op_pkg::alu_flags_t flag_wdata,
    input  logic [`ALU_DATA_W-1:0] result,
    input  alu_op_pkg::alu_flags_t flags,
    input  logic                   done
);
    import alu_op_pkg::*;
    import alu_bus_pkg::*;

    logic new_req;
    logic cmd_wr;
    logic cmd_pend;  // command running, ack waits for done

    assign new_req    = cyc & stb & ~ack & ~cmd_pend;
    assign cmd_wr     = new_req & we & (adr == reg_cmd);
    assign flag_wr    = new_req & we & (adr == reg_flags);
    assign flag_wdata = dat_w[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack      <= 1'b0;
            start    <= 1'b0;
            cmd_pend <= 1'b0;
            op       <= alu_add;
            width    <= width_byte;
        end else begin
            start <= cmd_wr;
            ack   <= (new_req & ~cmd_wr) | done;  // commands answer on done
            if (cmd_wr) begin
                cmd_pend <= 1'b1;
                op       <= alu_op_e'(dat_w[cmd_op_lsb +: 4]);
                width    <= alu_width_e'(dat_w[cmd_width_lsb +: 2]);
            end else if (done) begin
                cmd_pend <= 1'b0;
            end
        end
    end

    // operand registers
    always_ff @(posedge clk) begin
        if (new_req && we && adr == reg_opa)
            opa <= dat_w;
        if (new_req && we && adr == reg_opb)
            opb <= dat_w;
    end

    always_comb begin
        dat_r = '0;
        case (adr)
            reg_opa:    dat_r = opa;
            reg_opb:    dat_r = opb;
            reg_flags:  dat_r[7:0] = flags;
            reg_result: dat_r = result;
            default:    dat_r = '0;  // cmd is write only
        endcase
    end

    // answer only a request that is still standing
    assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb));

    // the result side only finishes what this side launched
    assert property (@(posedge clk) disable iff (rst) done |-> cmd_pend);

endmodule

`default_nettype wire

// ==== source/alu_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "alu_cfg.svh"

module alu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`ALU_ADR_W-1:0]  adr,
    input  logic [`ALU_DATA_W-1:0] dat_w,
    output logic                   ack,
    output logic [`ALU_DATA_W-1:0] dat_r
);
    import alu_op_pkg::*;

    // decode to execute
    logic                   start;
    alu_op_e                op;
    alu_width_e             width;
    logic [`ALU_DATA_W-1:0] opa;
    logic [`ALU_DATA_W-1:0] opb;

    // execute to result
    logic                   valid;
    logic                   write_result;
    logic [`ALU_DATA_W-1:0] next_result;
    alu_flags_t             next_flags;

    // bus flag writes and the architectural registers
    logic                   flag_wr;
    alu_flags_t             flag_wdata;
    logic [`ALU_DATA_W-1:0] result;
    alu_flags_t             flags;
    logic                   done;

    alu_decode u_decode (.*);

    alu_execute u_execute (.*);

    alu_result u_result (.*);

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);
    localparam real half_period = 10.0;  // 20 ns period

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== sim/tb_alu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "alu_cfg.svh"

module tb_alu;
    import alu_op_pkg::*;
    import alu_bus_pkg::*;

    // bus 3, add/sub 24, adc/sbc 12, cp 6, logic 9, shifts 72
    localparam int n_ops = 126;
    localparam int cycle_limit = n_ops * 40;  // one operation needs under 30 cycles

    logic                   clk;
    logic                   rst;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`ALU_ADR_W-1:0]  adr;
    logic [`ALU_DATA_W-1:0] dat_w;
    logic                   ack;
    logic [`ALU_DATA_W-1:0] dat_r;
    logic [`ALU_DATA_W-1:0] exp_result;  // result register as the model sees it
    int                     errors;
    int                     checks;
    int                     cycles = 0;
    alu_width_e             widths[3] = '{width_byte, width_word, width_long};
    int                     counts[3] = '{1, 5, 0};

    tb_clock u_clock (.clk(clk));

    alu_top uut (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic wb_write(input reg_addr_e a, input logic [31:0] d, output int lat);
        lat   = 0;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!ack);
        @(posedge clk);  // stb drops in the cycle after ack
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input reg_addr_e a, output logic [31:0] d);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        d = dat_r;
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic check_data(input string tname, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", tname, exp, act);
        end
    endtask

    task automatic check_flags(input string tname, input alu_flags_t exp, input alu_flags_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s flags: expected %b, actual %b", tname, exp, act);
        end
    endtask

    task automatic check_cycles(input string tname, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("mismatch %s ack cycles: expected %0d, actual %0d", tname, exp, act);
        end
    endtask

    function automatic int width_bits(input alu_width_e w);
        case (w)
            width_byte: return 8;
            width_word: return 16;
            default:    return 32;
        endcase
    endfunction

    function automatic logic is_shift_op(input alu_op_e op);
        return op inside {alu_rlc, alu_rrc, alu_rl, alu_rr, alu_sla, alu_sra, alu_sll, alu_srl};
    endfunction

    function automatic longint to_signed(input longint unsigned x, input int n);
        return x[n-1] ? longint'(x) - (longint'(1) << n) : longint'(x);
    endfunction

    // one bit per step with the carry chained from step to step
    function automatic longint unsigned shift_model(input alu_op_e op, input int n,
            input longint unsigned x, input int steps, input logic c_in, output logic c_out);
        longint unsigned v;
        logic c;
        logic msb;
        logic lsb;
        logic fill;
        int i;
        v = x;
        c = c_in;
        for (i = 0; i < steps; i++) begin
            msb = v[n-1];
            lsb = v[0];
            if (op inside {alu_rlc, alu_rl, alu_sla, alu_sll}) begin
                fill = (op == alu_rlc) ? msb : (op == alu_rl) ? c : 1'b0;
                v = ((v << 1) | 64'(fill)) & ((64'd1 << n) - 64'd1);
                c = msb;
            end else begin
                fill = (op == alu_rrc) ? lsb : (op == alu_rr) ? c : (op == alu_sra) ? msb : 1'b0;
                v = (v >> 1) | (64'(fill) << (n - 1));
                c = lsb;
            end
        end
        c_out = c;
        return v;
    endfunction

    task automatic model_op(input alu_op_e op, input alu_width_e w, input logic [31:0] a,
            input logic [31:0] b, input logic cin_flag, output logic [31:0] r,
            output alu_flags_t f);
        int n;
        int ones;
        longint unsigned m;
        longint unsigned ua;
        longint unsigned ub;
        longint unsigned sum;
        longint sr;
        longint lim;
        logic cin;
        logic c;
        logic h;
        logic v;
        logic [31:0] low;
        n   = width_bits(w);
        m   = (64'd1 << n) - 64'd1;
        lim = longint'(1) << (n - 1);
        ua  = 64'(a) & m;
        ub  = 64'(b) & m;
        cin = (op == alu_adc || op == alu_sbc) ? cin_flag : 1'b0;
        c   = 1'b0;
        h   = 1'b0;
        sr  = 0;
        case (op)
            alu_add, alu_adc: begin
                sum = ua + ub + 64'(cin);
                c   = sum[n];
                h   = (int'(a[3:0]) + int'(b[3:0]) + int'(cin)) > 15;
                sr  = to_signed(ua, n) + to_signed(ub, n) + longint'(cin);
            end
            alu_sub, alu_sbc, alu_cp: begin
                sum = ua - ub - 64'(cin);
                c   = ua < ub + 64'(cin);  // borrow out of the width
                h   = int'(a[3:0]) < int'(b[3:0]) + int'(cin);
                sr  = to_signed(ua, n) - to_signed(ub, n) - longint'(cin);
            end
            alu_and: begin
                sum = ua & ub;
                h   = 1'b1;
            end
            alu_or:  sum = ua | ub;
            alu_xor: sum = ua ^ ub;
            default: sum = shift_model(op, n, ua, (b[3:0] == 4'd0) ? 16 : int'(b[3:0]),
                                       cin_flag, c);
        endcase
        low  = 32'(sum & m);
        r    = (a & ~32'(m)) | low;
        ones = (n == 8) ? $countones(low[7:0]) : $countones(low[15:0]);
        if (op inside {alu_add, alu_adc, alu_sub, alu_sbc, alu_cp})
            v = (sr >= lim) || (sr < -lim);  // signed overflow
        else
            v = (ones % 2) == 0;  // even parity
        f             = '0;
        f[flag_s_bit] = low[n-1];
        f[flag_z_bit] = (low == 32'd0);
        f[flag_h_bit] = h;
        f[flag_v_bit] = v;
        f[flag_n_bit] = op inside {alu_sub, alu_sbc, alu_cp};
        f[flag_c_bit] = c;
    endtask

    // whole command sequence over the bus with result, flags and ack latency checked
    task automatic run_op(input string test, input alu_op_e op, input alu_width_e w,
            input logic [31:0] a, input logic [31:0] b, input alu_flags_t fin);
        string tname;
        int lat;
        int exp_lat;
        logic [31:0] r;
        logic [31:0] got;
        alu_flags_t f;
        tname = $sformatf("%s %s %s", test, op.name(), w.name());
        model_op(op, w, a, b, fin[flag_c_bit], r, f);
        if (op != alu_cp)
            exp_result = r;
        exp_lat = is_shift_op(op) ? ((b[3:0] == 4'd0) ? 16 : int'(b[3:0])) + 2 : 3;
        wb_write(reg_opa, a, lat);
        wb_write(reg_opb, b, lat);
        wb_write(reg_flags, 32'(fin), lat);
        wb_write(reg_cmd, (32'(op) << cmd_op_lsb) | (32'(w) << cmd_width_lsb), lat);
        check_cycles(tname, exp_lat, lat);
        wb_read(reg_result, got);
        check_data(tname, exp_result, got);
        wb_read(reg_flags, got);
        check_flags(tname, f, got[7:0]);
    endtask

    task automatic test_bus();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        int lat;
        wb_read(reg_result, got);
        check_data("bus reset result", 32'd0, got);
        wb_read(reg_flags, got);
        check_data("bus reset flags", 32'd0, got);
        wb_write(reg_flags, 32'h0000_00ff, lat);
        wb_read(reg_flags, got);
        check_flags("bus flag write", 8'hd7, got[7:0]);  // bits 5 and 3 hold no flag
        a = $urandom;
        b = $urandom;
        wb_write(reg_opa, a, lat);
        check_cycles("bus opa write", 1, lat);
        wb_write(reg_opb, b, lat);
        wb_read(reg_opa, got);
        check_data("bus opa readback", a, got);
        wb_read(reg_opb, got);
        check_data("bus opb readback", b, got);
        run_op("bus", alu_xor, width_long, a, b, 8'h00);
        run_op("bus", alu_srl, width_word, a, {b[31:4], 4'd7}, 8'h00);
        run_op("bus", alu_rl, width_long, a, {b[31:4], 4'd0}, 8'h01);
    endtask

    task automatic test_add_sub();
        foreach (widths[i]) begin
            repeat (4) begin
                run_op("add_sub", alu_add, widths[i], $urandom, $urandom, alu_flags_t'($urandom));
                run_op("add_sub", alu_sub, widths[i], $urandom, $urandom, alu_flags_t'($urandom));
            end
        end
    endtask

    task automatic test_adc_sbc();
        foreach (widths[i]) begin
            // all ones plus carry and zero minus borrow wrap past the width
            run_op("adc_sbc", alu_adc, widths[i], 32'hffff_ffff, 32'd0, 8'h01);
            run_op("adc_sbc", alu_sbc, widths[i], 32'd0, 32'd0, 8'h01);
            run_op("adc_sbc", alu_adc, widths[i], $urandom, $urandom, 8'h01);
            run_op("adc_sbc", alu_sbc, widths[i], $urandom, $urandom, 8'h00);
        end
    endtask

    task automatic test_cp();
        logic [31:0] a;
        foreach (widths[i]) begin
            a = $urandom;
            run_op("cp", alu_cp, widths[i], $urandom, $urandom, 8'h00);
            run_op("cp", alu_cp, widths[i], a, a, 8'h01);  // equal gives Z
        end
    endtask

    task automatic test_logic();
        foreach (widths[i]) begin
            run_op("logic", alu_and, widths[i], $urandom, $urandom, alu_flags_t'($urandom));
            run_op("logic", alu_or, widths[i], $urandom, $urandom, alu_flags_t'($urandom));
            run_op("logic", alu_xor, widths[i], $urandom, $urandom, alu_flags_t'($urandom));
        end
    endtask

    task automatic test_shifts();
        int k;
        alu_op_e op;
        logic [31:0] b;
        for (k = 0; k < 8; k++) begin
            op = alu_op_e'(int'(alu_rlc) + k);
            foreach (widths[i]) begin
                foreach (counts[j]) begin
                    b      = $urandom;
                    b[3:0] = 4'(counts[j]);  // 0 means 16 steps
                    run_op("shift", op, widths[i], $urandom, b, alu_flags_t'($urandom));
                end
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        errors     = 0;
        checks     = 0;
        exp_result = '0;
        void'($urandom(54));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_bus();
        test_add_sub();
        test_adc_sbc();
        test_cp();
        test_logic();
        test_shifts();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/alu_op_pkg.sv
common/alu_bus_pkg.sv
alu_core/alu_shift.sv
alu_core/alu_execute.sv
source/alu_result.sv
source/alu_decode.sv
source/alu_top.sv
sim/tb_clock.sv
sim/tb_alu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_alu
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
